// ==== Bender.yml ====
package:
  name: lvda

sources:
  - verilog/lvda_pkg.sv
  - verilog/input_filter.sv
  - verilog/pio_decode.sv
  - verilog/discrete_out_regs.sv
  - verilog/interrupt_proc.sv
  - verilog/lvda.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/lvda_tb.sv

// ==== files.f ====
+incdir+include
verilog/lvda_pkg.sv
verilog/input_filter.sv
verilog/pio_decode.sv
verilog/discrete_out_regs.sv
verilog/interrupt_proc.sv
verilog/lvda.sv
tests/lvda_tb.sv

// ==== include/lvda_tb_vectors.svh ====
`ifndef LVDA_TB_VECTORS_SVH
`define LVDA_TB_VECTORS_SVH

    localparam lvda_pkg::pio_addr_t A_OUT  = lvda_pkg::ADDR_DISC_OUT;
    localparam lvda_pkg::pio_addr_t A_IN   = lvda_pkg::ADDR_DISC_IN;
    localparam lvda_pkg::pio_addr_t A_INT  = lvda_pkg::ADDR_INT;
    localparam lvda_pkg::pio_addr_t A_CNT  = lvda_pkg::ADDR_COUNT;
    localparam lvda_pkg::pio_addr_t A_NONE = 9'h1F0;

    localparam int NUM_VECTORS = 35;

    // Columns: op, addr, data, dis, intr, wait cycles, expected brd,
    // expected rdata, expected intc, random data.
    vector_t vectors [NUM_VECTORS] = '{
        '{OP_WAIT,   A_NONE, 26'h0,       8'h00, 7'h00, 2,  26'h0,       26'h0,       0, 0},
        // Buffer register and unmapped addresses.
        '{OP_WRITE,  A_OUT,  26'h2A5C3F1, 8'h00, 7'h00, 0,  26'h2A5C3F1, 26'h0,       0, 0},
        '{OP_READ,   A_OUT,  26'h0,       8'h00, 7'h00, 0,  26'h2A5C3F1, 26'h2A5C3F1, 0, 0},
        '{OP_READ,   A_NONE, 26'h0,       8'h00, 7'h00, 0,  26'h2A5C3F1, 26'h0,       0, 0},
        '{OP_WRITE,  A_NONE, 26'h3FFFFFF, 8'h00, 7'h00, 0,  26'h2A5C3F1, 26'h0,       0, 0},
        '{OP_WRITE,  A_IN,   26'h1234567, 8'h00, 7'h00, 0,  26'h2A5C3F1, 26'h0,       0, 0},
        // Data and expected values of these rows come from the LFSR.
        '{OP_WRITE,  A_OUT,  26'h0,       8'h00, 7'h00, 0,  26'h0,       26'h0,       0, 1},
        '{OP_READ,   A_OUT,  26'h0,       8'h00, 7'h00, 0,  26'h0,       26'h0,       0, 1},
        '{OP_WRITE,  A_OUT,  26'h0,       8'h00, 7'h00, 0,  26'h0,       26'h0,       0, 1},
        '{OP_READ,   A_OUT,  26'h0,       8'h00, 7'h00, 0,  26'h0,       26'h0,       0, 1},
        '{OP_WRITE,  A_OUT,  26'h0001234, 8'h00, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        // Discrete inputs, including a 2-cycle glitch on bit 0 that is read
        // back while it would still be passing through the synchronizer.
        '{OP_INPUTS, A_NONE, 26'h0,       8'hA5, 7'h00, 12, 26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_IN,   26'h0,       8'hA5, 7'h00, 0,  26'h0001234, 26'h00000A5, 0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'hA4, 7'h00, 2,  26'h0001234, 26'h0,       0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'hA5, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_IN,   26'h0,       8'hA5, 7'h00, 0,  26'h0001234, 26'h00000A5, 0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'h3C, 7'h00, 12, 26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_IN,   26'h0,       8'h3C, 7'h00, 0,  26'h0001234, 26'h000003C, 0, 0},
        // External interrupt on line 3, then on line 7.
        '{OP_INPUTS, A_NONE, 26'h0,       8'h3C, 7'h04, 12, 26'h0001234, 26'h0,       1, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h04, 0,  26'h0001234, 26'h0000008, 1, 0},
        '{OP_WRITE,  A_INT,  26'h0000008, 8'h3C, 7'h04, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h04, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'h3C, 7'h00, 12, 26'h0001234, 26'h0,       0, 0},
        '{OP_WRITE,  A_CNT,  26'h0000014, 8'h3C, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_WAIT,   A_NONE, 26'h0,       8'h3C, 7'h00, 30, 26'h0001234, 26'h0,       1, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h00, 0,  26'h0001234, 26'h0000001, 1, 0},
        '{OP_WRITE,  A_INT,  26'h0000001, 8'h3C, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_WRITE,  A_CNT,  26'h0,       8'h3C, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_WAIT,   A_NONE, 26'h0,       8'h3C, 7'h00, 30, 26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h00, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'h3C, 7'h40, 12, 26'h0001234, 26'h0,       1, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h40, 0,  26'h0001234, 26'h0000080, 1, 0},
        '{OP_WRITE,  A_INT,  26'h3FFFFFF, 8'h3C, 7'h40, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_READ,   A_INT,  26'h0,       8'h3C, 7'h40, 0,  26'h0001234, 26'h0,       0, 0},
        '{OP_INPUTS, A_NONE, 26'h0,       8'h3C, 7'h00, 12, 26'h0001234, 26'h0,       0, 0}
    };

`endif

// ==== tests/lvda_tb.sv ====
module lvda_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;
    localparam int ACK_TIMEOUT = 20;
    localparam int HOLD_CYCLES = 3;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_INPUTS,
        OP_WAIT
    } op_t;

    typedef struct packed {
        op_t                 op;
        lvda_pkg::pio_addr_t addr;
        lvda_pkg::pio_data_t data;
        lvda_pkg::disc_in_t  dis;
        lvda_pkg::intr_in_t  intr;
        logic [7:0]          cycles;
        lvda_pkg::brd_t      exp_brd;
        lvda_pkg::pio_data_t exp_rdata;
        logic                exp_intc;
        logic                rand_data;
    } vector_t;

    `include "lvda_tb_vectors.svh"

    logic                sim_clk;
    logic                rst_n;
    logic                pio_req;
    lvda_pkg::pio_cmd_t  pio_cmd;
    lvda_pkg::disc_in_t  dis;
    lvda_pkg::intr_in_t  intr_raw;
    logic                pio_ack;
    lvda_pkg::pio_data_t pio_rdata;
    lvda_pkg::brd_t      brd;
    logic                intc;

    int          value_errors;
    int          protocol_errors;
    int          row_idx;
    logic [15:0] lfsr_state;

    lvda lvda_i (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .pio_req  (pio_req),
        .pio_cmd  (pio_cmd),
        .dis      (dis),
        .intr_raw (intr_raw),
        .pio_ack  (pio_ack),
        .pio_rdata(pio_rdata),
        .brd      (brd),
        .intc     (intc)
    );

    always #(CLK_PERIOD / 2) sim_clk = ~sim_clk;

    // ######################################################################
    // Random data and compare tasks
    // ######################################################################

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // One LFSR step per data bit.
    task automatic next_random(output lvda_pkg::pio_data_t word);
        word = '0;
        for (int i = 0; i < $bits(lvda_pkg::pio_data_t); i++) begin
            word       = {word[$bits(lvda_pkg::pio_data_t)-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_brd(input string name, input lvda_pkg::brd_t expected,
                             input lvda_pkg::brd_t actual);
        if (actual !== expected) begin
            $display("Fail %s row %0d: expected 0x%h, got 0x%h", name, row_idx, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_data(input string name, input lvda_pkg::pio_data_t expected,
                              input lvda_pkg::pio_data_t actual);
        if (actual !== expected) begin
            $display("Fail %s row %0d: expected 0x%h, got 0x%h", name, row_idx, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s row %0d: expected 0x%h, got 0x%h", name, row_idx, expected, actual);
            value_errors++;
        end
    endtask

    // ######################################################################
    // Four-phase PIO transfer
    // ######################################################################

    task automatic pio_transfer(input lvda_pkg::pio_cmd_t cmd,
                                output lvda_pkg::pio_data_t rdata,
                                output lvda_pkg::brd_t brd_ack);
        int cycles;
        rdata   = '0;
        brd_ack = brd;
        pio_cmd = cmd;
        pio_req = 1'b1;
        cycles  = 0;
        @(negedge sim_clk);
        while (!pio_ack && cycles < ACK_TIMEOUT) begin
            @(negedge sim_clk);
            cycles++;
        end
        if (!pio_ack) begin
            $display("Row %0d: pio_ack never rose after pio_req was raised", row_idx);
            protocol_errors++;
            pio_req = 1'b0;
        end else begin
            rdata   = pio_rdata;
            brd_ack = brd;
            // The acknowledge and its data must hold while the request stays up.
            repeat (HOLD_CYCLES) begin
                @(negedge sim_clk);
                check_bit("pio_ack", 1'b1, pio_ack);
                check_data("pio_rdata", rdata, pio_rdata);
            end
            pio_req = 1'b0;
            cycles  = 0;
            @(negedge sim_clk);
            while (pio_ack && cycles < ACK_TIMEOUT) begin
                @(negedge sim_clk);
                cycles++;
            end
            if (pio_ack) begin
                $display("Row %0d: pio_ack stayed high after pio_req was dropped", row_idx);
                protocol_errors++;
            end
        end
    endtask

    // ######################################################################
    // Table loop
    // ######################################################################

    initial begin
        vector_t             row;
        lvda_pkg::pio_cmd_t  cmd;
        lvda_pkg::pio_data_t rdata;
        lvda_pkg::brd_t      brd_ack;
        lvda_pkg::pio_data_t rand_word;
        lvda_pkg::brd_t      exp_brd;
        lvda_pkg::pio_data_t exp_rdata;

        sim_clk         = 1'b0;
        rst_n           = 1'b0;
        pio_req         = 1'b0;
        pio_cmd         = '0;
        dis             = '0;
        intr_raw        = '0;
        value_errors    = 0;
        protocol_errors = 0;
        row_idx         = -1;
        lfsr_state      = 16'd14752;
        rand_word       = '0;

        repeat (RESET_CYCLES) @(negedge sim_clk);
        rst_n = 1'b1;
        check_bit("pio_ack", 1'b0, pio_ack);
        check_bit("intc", 1'b0, intc);
        check_brd("brd", '0, brd);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            row       = vectors[i];
            row_idx   = i;
            rdata     = '0;
            exp_brd   = row.exp_brd;
            exp_rdata = row.exp_rdata;
            // Random rows only touch the buffer register, so brd follows the last word.
            if (row.rand_data) begin
                if (row.op == OP_WRITE) begin
                    next_random(rand_word);
                end
                exp_brd = lvda_pkg::brd_t'(rand_word);
                if (row.op == OP_READ) begin
                    exp_rdata = rand_word;
                end
            end
            cmd.addr  = row.addr;
            cmd.write = (row.op == OP_WRITE);
            cmd.wdata = row.rand_data ? rand_word : row.data;
            case (row.op)
                OP_WRITE, OP_READ: pio_transfer(cmd, rdata, brd_ack);
                OP_INPUTS: begin
                    dis      = row.dis;
                    intr_raw = row.intr;
                end
                default: ;
            endcase
            repeat (row.cycles) @(negedge sim_clk);
            if (row.op == OP_READ) begin
                check_data("pio_rdata", exp_rdata, rdata);
            end
            // A written word is already in brd when the acknowledge is seen.
            if (row.op == OP_WRITE || row.op == OP_READ) begin
                check_brd("brd", exp_brd, brd_ack);
            end
            check_brd("brd", exp_brd, brd);
            check_bit("intc", row.exp_intc, intc);
            check_bit("pio_ack", 1'b0, pio_ack);
        end

        $display("Errors: %0d value, %0d handshake", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        int max_cycles;
        max_cycles = 0;
        foreach (vectors[i]) begin
            if (vectors[i].cycles > max_cycles) begin
                max_cycles = vectors[i].cycles;
            end
        end
        #(NUM_VECTORS * (max_cycles + 20) * CLK_PERIOD);
        $display("Watchdog expired before the table finished at row %0d", row_idx);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verilog/discrete_out_regs.sv ====
module discrete_out_regs (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  lvda_pkg::pio_strobe_t strobe,
    output lvda_pkg::brd_t        brd
);

    lvda_pkg::brd_t brd_d;

    // The buffer register holds its value until the computer
    // writes a new word to it.
    always_comb begin
        brd_d = brd;
        if (strobe.disc_out_we) begin
            brd_d = lvda_pkg::brd_t'(strobe.wdata);
        end
    end

    // These lines drive vehicle discretes, so they start out inactive.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            brd <= '0;
        end else begin
            brd <= brd_d;
        end
    end

endmodule

// ==== verilog/input_filter.sv ====
module input_filter #(
    parameter int WIDTH = 8
) (
    input  logic             sim_clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] clean
);

    logic [WIDTH-1:0] sync_a;
    logic [WIDTH-1:0] sync_b;

    // The raw lines are asynchronous to the clock.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= raw;
            sync_b <= sync_a;
        end
    end

    // ######################################################################
    // Per-bit stability counters
    // ######################################################################

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        lvda_pkg::filt_cnt_t stable_cnt;

        // The counter only runs while the synchronized bit disagrees with
        // the filtered output, so any glitch shorter than the window
        // drops it back to zero.
        always_ff @(posedge sim_clk or negedge rst_n) begin
            if (!rst_n) begin
                stable_cnt <= '0;
                clean[i]   <= 1'b0;
            end else if (sync_b[i] == clean[i]) begin
                stable_cnt <= '0;
            end else if (stable_cnt == lvda_pkg::filt_cnt_t'(lvda_pkg::FILTER_CYCLES - 1)) begin
                stable_cnt <= '0;
                clean[i]   <= sync_b[i];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/interrupt_proc.sv ====
module interrupt_proc (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  lvda_pkg::pio_strobe_t  strobe,
    input  lvda_pkg::intr_in_t     intr,
    output lvda_pkg::int_pending_t pending,
    output logic                   intc
);

    lvda_pkg::intr_in_t     intr_q;
    lvda_pkg::intr_in_t     intr_rise;
    lvda_pkg::count_t       count_q;
    logic                   expire;
    lvda_pkg::int_pending_t pend_set;
    lvda_pkg::int_pending_t pend_clr;
    lvda_pkg::int_pending_t pend_d;

    // ######################################################################
    // Countdown timer
    // ######################################################################

    // Only a decrement from 1 to 0 counts as expiry; a reload or a load
    // of zero does not.
    assign expire = !strobe.count_load && (count_q == lvda_pkg::count_t'(1));

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (strobe.count_load) begin
            count_q <= strobe.wdata[lvda_pkg::COUNT_W-1:0];
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // ######################################################################
    // Pending register
    // ######################################################################

    always_comb begin
        intr_rise = intr & ~intr_q;
        pend_set  = {intr_rise, expire};
        pend_clr  = '0;
        if (strobe.int_reset) begin
            pend_clr = strobe.wdata[lvda_pkg::PENDING_W-1:0];
        end
        // A new event wins over a clear in the same cycle.
        pend_d = (pending & ~pend_clr) | pend_set;
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_q  <= '0;
            pending <= '0;
        end else begin
            intr_q  <= intr;
            pending <= pend_d;
        end
    end

    // Built from the value loaded into the pending register, so intc
    // rises and falls on the same edge as the pending bits.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            intc <= 1'b0;
        end else begin
            intc <= |pend_d;
        end
    end

endmodule

// ==== verilog/lvda.sv ====
module lvda (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic                  pio_req,
    input  lvda_pkg::pio_cmd_t    pio_cmd,
    input  lvda_pkg::disc_in_t    dis,
    input  lvda_pkg::intr_in_t    intr_raw,
    output logic                  pio_ack,
    output lvda_pkg::pio_data_t   pio_rdata,
    output lvda_pkg::brd_t        brd,
    output logic                  intc
);

    lvda_pkg::disc_in_t     disc_clean;
    lvda_pkg::intr_in_t     intr_clean;
    lvda_pkg::pio_strobe_t  strobe;
    lvda_pkg::int_pending_t pending;

    // ######################################################################
    // Input protection
    // ######################################################################

    input_filter #(
        .WIDTH($bits(lvda_pkg::disc_in_t))
    ) dis_filter_i (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .raw    (dis),
        .clean  (disc_clean)
    );

    input_filter #(
        .WIDTH($bits(lvda_pkg::intr_in_t))
    ) intr_filter_i (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .raw    (intr_raw),
        .clean  (intr_clean)
    );

    // ######################################################################
    // PIO decode and registers
    // ######################################################################

    pio_decode pio_decode_i (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .pio_req  (pio_req),
        .pio_cmd  (pio_cmd),
        .brd      (brd),
        .disc_in  (disc_clean),
        .pending  (pending),
        .strobe   (strobe),
        .pio_ack  (pio_ack),
        .pio_rdata(pio_rdata)
    );

    discrete_out_regs disc_out_i (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .strobe (strobe),
        .brd    (brd)
    );

    interrupt_proc int_proc_i (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .strobe (strobe),
        .intr   (intr_clean),
        .pending(pending),
        .intc   (intc)
    );

endmodule

// ==== verilog/lvda_pkg.sv ====
package lvda_pkg;

    // ######################################################################
    // Widths
    // ######################################################################

    localparam int PIO_ADDR_W = 9;
    localparam int PIO_DATA_W = 26;
    localparam int BRD_W      = 26;
    localparam int DISC_IN_W  = 8;
    localparam int INTR_W     = 7;
    localparam int PENDING_W  = INTR_W + 1;
    localparam int COUNT_W    = 16;

    // A filtered bit follows its input after this many equal samples.
    localparam int FILTER_CYCLES = 4;
    localparam int FILTER_CNT_W  = $clog2(FILTER_CYCLES);

    // ######################################################################
    // Types
    // ######################################################################

    typedef logic [PIO_ADDR_W-1:0]   pio_addr_t;
    typedef logic [PIO_DATA_W-1:0]   pio_data_t;
    typedef logic [BRD_W-1:0]        brd_t;
    typedef logic [DISC_IN_W-1:0]    disc_in_t;
    typedef logic [INTR_W-1:0]       intr_in_t;
    typedef logic [COUNT_W-1:0]      count_t;
    typedef logic [FILTER_CNT_W-1:0] filt_cnt_t;

    // Bit 0 is the countdown expiry, bits 1 to 7 are the external lines.
    typedef logic [PENDING_W-1:0] int_pending_t;

    typedef struct packed {
        pio_addr_t addr;
        logic      write;
        pio_data_t wdata;
    } pio_cmd_t;

    typedef struct packed {
        logic      disc_out_we;
        logic      int_reset;
        logic      count_load;
        pio_data_t wdata;
    } pio_strobe_t;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK,
        WAIT_REL
    } pio_state_t;

    // ######################################################################
    // PIO address map
    // ######################################################################

    localparam pio_addr_t ADDR_DISC_OUT = 9'h004;
    localparam pio_addr_t ADDR_COUNT    = 9'h010;
    localparam pio_addr_t ADDR_INT      = 9'h01C;
    localparam pio_addr_t ADDR_DISC_IN  = 9'h038;

endpackage

// ==== verilog/pio_decode.sv ====
module pio_decode (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  logic                   pio_req,
    input  lvda_pkg::pio_cmd_t     pio_cmd,
    input  lvda_pkg::brd_t         brd,
    input  lvda_pkg::disc_in_t     disc_in,
    input  lvda_pkg::int_pending_t pending,
    output lvda_pkg::pio_strobe_t  strobe,
    output logic                   pio_ack,
    output lvda_pkg::pio_data_t    pio_rdata
);

    lvda_pkg::pio_state_t state;
    lvda_pkg::pio_state_t state_d;
    lvda_pkg::pio_cmd_t   cmd_q;
    lvda_pkg::pio_data_t  rdata_sel;
    logic                 exec_write;

    // ######################################################################
    // Four-phase handshake
    // ######################################################################

    always_comb begin
        state_d = state;
        case (state)
            lvda_pkg::IDLE: begin
                if (pio_req) begin
                    state_d = lvda_pkg::EXEC;
                end
            end
            lvda_pkg::EXEC: begin
                state_d = lvda_pkg::ACK;
            end
            lvda_pkg::ACK: begin
                // The acknowledge is held for as long as the computer
                // keeps its request up.
                if (!pio_req) begin
                    state_d = lvda_pkg::WAIT_REL;
                end
            end
            default: begin
                state_d = lvda_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= lvda_pkg::IDLE;
            pio_ack <= 1'b0;
        end else begin
            state   <= state_d;
            pio_ack <= (state_d == lvda_pkg::ACK);
        end
    end

    // The command is captured when the request is first seen.
    always_ff @(posedge sim_clk) begin
        if (state == lvda_pkg::IDLE && pio_req) begin
            cmd_q <= pio_cmd;
        end
    end

    // ######################################################################
    // Address decode
    // ######################################################################

    always_comb begin
        exec_write         = (state == lvda_pkg::EXEC) && cmd_q.write;
        strobe.disc_out_we = exec_write && (cmd_q.addr == lvda_pkg::ADDR_DISC_OUT);
        strobe.int_reset   = exec_write && (cmd_q.addr == lvda_pkg::ADDR_INT);
        strobe.count_load  = exec_write && (cmd_q.addr == lvda_pkg::ADDR_COUNT);
        strobe.wdata       = cmd_q.wdata;
    end

    // Unmapped addresses read as zero.
    always_comb begin
        case (cmd_q.addr)
            lvda_pkg::ADDR_DISC_OUT: rdata_sel = lvda_pkg::pio_data_t'(brd);
            lvda_pkg::ADDR_DISC_IN:  rdata_sel = lvda_pkg::pio_data_t'(disc_in);
            lvda_pkg::ADDR_INT:      rdata_sel = lvda_pkg::pio_data_t'(pending);
            default:                 rdata_sel = '0;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (state == lvda_pkg::EXEC) begin
            pio_rdata <= rdata_sel;
        end
    end

endmodule
